//--- mempool_pkg.sv
// #########################################################################
// Address map, L2 geometry, boot ROM image and shared request types.
// L2 is 4 KiB over four word-interleaved banks. Only word accesses exist.
// #########################################################################

package mempool_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // System address map
  localparam addr_t CtrlRegistersBaseAddr = 32'h4000_0000;
  localparam addr_t CtrlRegistersEndAddr  = 32'h4000_FFFF;
  localparam addr_t L2MemoryBaseAddr      = 32'h8000_0000;
  localparam addr_t L2Size                = 32'h0000_1000;
  localparam addr_t L2MemoryEndAddr       = L2MemoryBaseAddr + L2Size - 1;
  localparam addr_t BootromBaseAddr       = 32'hA000_0000;
  localparam addr_t BootromEndAddr        = 32'hA000_FFFF;

  // L2 geometry, bank from addr[3:2] and row from addr[11:4]
  localparam int unsigned NumL2Banks     = 4;
  localparam int unsigned L2BankNumWords = 256;
  localparam int unsigned L2BankIdxWidth = $clog2(NumL2Banks);
  localparam int unsigned L2RowWidth     = $clog2(L2BankNumWords);
  localparam int unsigned L2WindowWidth  = AddrWidth - L2RowWidth - L2BankIdxWidth - ByteOffWidth;

  localparam int unsigned BootromNumWords = 8;
  localparam int unsigned BootromIdxWidth = $clog2(BootromNumWords);
  // Park loop, harts sleep in wfi until woken
  localparam data_t [0:BootromNumWords-1] BootromContent = '{
    0: 32'hf140_2573, // csrr a0, mhartid
    1: 32'h0000_0297, // auipc t0, 0
    2: 32'h01c2_8293,
    3: 32'h3052_9073, // mtvec
    4: 32'h3004_6073,
    5: 32'h1050_0073, // wfi
    6: 32'hffdf_f06f,
    7: 32'h0000_0013
  };

  localparam int unsigned NumCores     = 4;
  localparam addr_t       TCDMBaseAddr = 32'h0000_0000;
  localparam addr_t       TCDMSize     = 32'h0001_0000;

  // Control register indices, addr[5:2]
  localparam int unsigned RegIdxWidth    = 4;
  localparam int unsigned NumCtrlRegs    = 6;
  localparam logic [RegIdxWidth-1:0] RegEoc         = 4'd0;
  localparam logic [RegIdxWidth-1:0] RegWakeUp      = 4'd1;
  localparam logic [RegIdxWidth-1:0] RegTcdmStart   = 4'd2;
  localparam logic [RegIdxWidth-1:0] RegTcdmEnd     = 4'd3;
  localparam logic [RegIdxWidth-1:0] RegNumCores    = 4'd4;
  localparam logic [RegIdxWidth-1:0] RegRoCacheCtrl = 4'd5;

  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  typedef struct packed {
    logic [L2WindowWidth-1:0]  window;
    logic [L2RowWidth-1:0]     row;
    logic [L2BankIdxWidth-1:0] bank;
    logic [ByteOffWidth-1:0]   offset;
  } l2_addr_t;

  typedef struct packed {
    logic [AddrWidth-RegIdxWidth-ByteOffWidth-1:0] window;
    logic [RegIdxWidth-1:0]                        reg_idx;
    logic [ByteOffWidth-1:0]                       offset;
  } ctrl_addr_t;

  typedef union packed {
    l2_addr_t   l2;
    ctrl_addr_t ctrl;
  } sys_addr_u;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } host_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    data_t rdata;
  } host_rsp_t;

  typedef struct packed {
    logic      valid;
    target_e   target;
    logic      err;   // Illegal access, no target acts on it
    logic      we;
    sys_addr_u addr;
    data_t     wdata;
    strb_t     strb;
  } dec_req_t;

endpackage

//--- mempool_addr_decode.sv
// #########################################################################
// Stage 1: address map lookup. One request per cycle, no grant.
// Misaligned addresses are treated as the word that contains them.
// #########################################################################
`timescale 1ns/1ps

module mempool_addr_decode
  import mempool_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  host_req_t req_i,
  output dec_req_t  dec_o
);

  dec_req_t dec_d, dec_q;
  logic     in_l2, in_rom, in_ctrl;
  logic     mapped;
  logic     illegal;
  addr_t    ctrl_offset;

  assign in_l2   = (req_i.addr >= L2MemoryBaseAddr) && (req_i.addr <= L2MemoryEndAddr);
  assign in_rom  = (req_i.addr >= BootromBaseAddr) && (req_i.addr <= BootromEndAddr);
  assign in_ctrl = (req_i.addr >= CtrlRegistersBaseAddr) && (req_i.addr <= CtrlRegistersEndAddr);
  assign mapped  = in_l2 || in_rom || in_ctrl;

  // Only the first NumCtrlRegs words of the control window are backed
  assign ctrl_offset = req_i.addr - CtrlRegistersBaseAddr;

  always_comb begin
    dec_d.valid = req_i.valid;
    dec_d.we    = req_i.we;
    dec_d.addr  = req_i.addr;
    dec_d.wdata = req_i.wdata;
    dec_d.strb  = req_i.strb;
    if (in_l2) begin
      dec_d.target = TgtL2;
      illegal      = 1'b0;
    end else if (in_rom) begin
      dec_d.target = TgtBootrom;
      illegal      = req_i.we;             // ROM is read only
    end else if (in_ctrl) begin
      dec_d.target = TgtCtrl;
      illegal      = ctrl_offset >= NumCtrlRegs * StrbWidth;
    end else begin
      dec_d.target = TgtNone;
      illegal      = 1'b1;
    end
    dec_d.err = req_i.valid && illegal;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_q.valid <= 1'b0;
      dec_q.err   <= 1'b0;
    end else begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

  // Unmapped requests, and only those, leave as TgtNone with err raised
  assert property (@(posedge clk_i) disable iff (rst_i)
    dec_q.valid |-> ((dec_q.target == TgtNone) == !$past(mapped)) &&
                    ((dec_q.target != TgtNone) || dec_q.err));

endmodule

//--- mempool_l2_banks.sv
// #########################################################################
// Stage 2 L2 target: four word-interleaved byte-writable banks.
// Contents survive reset. Read data is valid one cycle after the access.
// #########################################################################
`timescale 1ns/1ps

module mempool_l2_banks
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  dec_req_t dec_i,
  output data_t    rdata_o
);

  logic                      access;
  logic [L2BankIdxWidth-1:0] bank;
  logic [L2RowWidth-1:0]     row;
  data_t [NumL2Banks-1:0]    bank_word;
  data_t                     rdata_q;

  assign access = dec_i.valid && !dec_i.err && (dec_i.target == TgtL2);
  assign bank   = dec_i.addr.l2.bank;
  assign row    = dec_i.addr.l2.row;

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_bank
    data_t mem [L2BankNumWords];
    logic  bank_we;

    assign bank_we = access && dec_i.we && (bank == b);

    always_ff @(posedge clk_i) begin
      if (bank_we) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (dec_i.strb[i]) begin
            mem[row][i*8 +: 8] <= dec_i.wdata[i*8 +: 8];
          end
        end
      end
    end

    assign bank_word[b] = mem[row]; // Asynchronous array read, registered below
  end

  always_ff @(posedge clk_i) begin
    if (access && !dec_i.we) begin
      rdata_q <= bank_word[bank];
    end
  end

  assign rdata_o = rdata_q;

  // Bank and row come straight from the host address
  assert property (@(posedge clk_i) disable iff (rst_i)
    access |-> !$isunknown({bank, row}));

endmodule

//--- mempool_bootrom.sv
// #########################################################################
// Stage 2 boot ROM target. Eight words repeat across the whole window.
// #########################################################################
`timescale 1ns/1ps

module mempool_bootrom
  import mempool_pkg::*;
(
  input  logic     clk_i,
  input  dec_req_t dec_i,
  output data_t    rdata_o
);

  logic                       rd_en;
  addr_t                      addr;
  logic [BootromIdxWidth-1:0] idx;
  data_t                      rdata_q;

  // Writes never get here, decode flags them as errors
  assign rd_en = dec_i.valid && !dec_i.err && (dec_i.target == TgtBootrom);
  assign addr  = dec_i.addr;
  assign idx   = addr[ByteOffWidth +: BootromIdxWidth];

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= BootromContent[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- mempool_ctrl_registers.sv
// #########################################################################
// Stage 2 control registers. Writes are whole words, strobes are ignored.
// Writes to read-only registers are dropped without an error.
// #########################################################################
`timescale 1ns/1ps

module mempool_ctrl_registers
  import mempool_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  dec_req_t            dec_i,
  output data_t               rdata_o,
  output logic [NumCores-1:0] wake_up_o,
  output data_t               eoc_o,
  output logic                eoc_valid_o,
  output logic                ro_cache_en_o
);

  logic                   access, wr_en;
  logic [RegIdxWidth-1:0] idx;
  data_t                  rd_word;
  data_t                  rdata_q;
  data_t                  eoc_q;
  logic                   eoc_valid_q;
  logic                   ro_cache_en_q;
  logic [NumCores-1:0]    wake_up_q;

  assign access = dec_i.valid && !dec_i.err && (dec_i.target == TgtCtrl);
  assign wr_en  = access && dec_i.we;
  assign idx    = dec_i.addr.ctrl.reg_idx;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q         <= '0;
      eoc_valid_q   <= 1'b0;
      ro_cache_en_q <= 1'b0;
      wake_up_q     <= '0;
    end else begin
      wake_up_q <= '0;                     // Single-cycle pulse
      if (wr_en) begin
        case (idx)
          RegEoc: begin
            eoc_q       <= dec_i.wdata;
            eoc_valid_q <= 1'b1;           // Sticky until reset
          end
          RegWakeUp:      wake_up_q     <= dec_i.wdata[NumCores-1:0];
          RegRoCacheCtrl: ro_cache_en_q <= dec_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (idx)
      RegEoc:         rd_word = eoc_q;
      RegTcdmStart:   rd_word = TCDMBaseAddr;
      RegTcdmEnd:     rd_word = TCDMBaseAddr + TCDMSize;
      RegNumCores:    rd_word = DataWidth'(NumCores);
      RegRoCacheCtrl: rd_word = {{(DataWidth-1){1'b0}}, ro_cache_en_q};
      default:        rd_word = '0;        // Wake-up reads as zero
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access && !dec_i.we) begin
      rdata_q <= rd_word;
    end
  end

  assign rdata_o       = rdata_q;
  assign wake_up_o     = wake_up_q;
  assign eoc_o         = eoc_q;
  assign eoc_valid_o   = eoc_valid_q;
  assign ro_cache_en_o = ro_cache_en_q;

  // A second pulse needs a fresh wake-up write
  assert property (@(posedge clk_i) disable iff (rst_i)
    (wake_up_o != '0) |=> (wake_up_o == '0) || $past(wr_en && (idx == RegWakeUp)));

endmodule

//--- mempool_resp_merge.sv
// #########################################################################
// Stage 3: picks the read data of the addressed target and forms the reply.
// Errors and writes return zero data.
// #########################################################################
`timescale 1ns/1ps

module mempool_resp_merge
  import mempool_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  dec_req_t  dec_i,
  input  data_t     l2_rdata_i,
  input  data_t     rom_rdata_i,
  input  data_t     ctrl_rdata_i,
  output host_rsp_t rsp_o,
  output logic      busy_o
);

  typedef struct packed {
    logic    valid;
    logic    we;
    logic    err;
    target_e target;
  } tag_t;

  tag_t  tag_q;
  data_t rdata;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tag_q <= '0;
    end else begin
      tag_q <= '{valid: dec_i.valid, we: dec_i.we, err: dec_i.err, target: dec_i.target};
    end
  end

  always_comb begin
    rdata = '0;
    if (tag_q.valid && !tag_q.err && !tag_q.we) begin
      case (tag_q.target)
        TgtL2:      rdata = l2_rdata_i;
        TgtBootrom: rdata = rom_rdata_i;
        TgtCtrl:    rdata = ctrl_rdata_i;
        default:    rdata = '0;
      endcase
    end
    rsp_o.valid = tag_q.valid;
    rsp_o.err   = tag_q.err;
    rsp_o.rdata = rdata;
  end

  assign busy_o = dec_i.valid || tag_q.valid; // Either stage holds a request

  // Decode only raises err on a real request
  assert property (@(posedge clk_i) disable iff (rst_i) rsp_o.err |-> rsp_o.valid);

endmodule

//--- mempool_system.sv
// #########################################################################
// Host port to L2, boot ROM and control registers. Fixed 2-cycle latency,
// a new request may enter every cycle and each gets exactly one reply.
// #########################################################################
`timescale 1ns/1ps

module mempool_system
  import mempool_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  host_req_t           req_i,
  output host_rsp_t           rsp_o,
  output logic [NumCores-1:0] wake_up_o,
  output data_t               eoc_o,
  output logic                eoc_valid_o,
  output logic                ro_cache_en_o,
  output logic                busy_o
);

  dec_req_t dec;
  data_t    l2_rdata;
  data_t    rom_rdata;
  data_t    ctrl_rdata;

  mempool_addr_decode i_addr_decode (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .req_i(req_i),
    .dec_o(dec  )
  );

  mempool_l2_banks i_l2_banks (
    .clk_i  (clk_i   ),
    .rst_i  (rst_i   ),
    .dec_i  (dec     ),
    .rdata_o(l2_rdata)
  );

  mempool_bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .dec_i  (dec      ),
    .rdata_o(rom_rdata)
  );

  mempool_ctrl_registers i_ctrl_registers (
    .clk_i        (clk_i        ),
    .rst_i        (rst_i        ),
    .dec_i        (dec          ),
    .rdata_o      (ctrl_rdata   ),
    .wake_up_o    (wake_up_o    ),
    .eoc_o        (eoc_o        ),
    .eoc_valid_o  (eoc_valid_o  ),
    .ro_cache_en_o(ro_cache_en_o)
  );

  mempool_resp_merge i_resp_merge (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .dec_i       (dec       ),
    .l2_rdata_i  (l2_rdata  ),
    .rom_rdata_i (rom_rdata ),
    .ctrl_rdata_i(ctrl_rdata),
    .rsp_o       (rsp_o     ),
    .busy_o      (busy_o    )
  );

endmodule

//--- tb_mempool_checker.sv
// ##########################################################################
// Watches the host port and side-band outputs, compares every cycle.
// L2 model survives reset like the real banks, registers do not.
// ##########################################################################
`timescale 1ns/1ps

module tb_mempool_checker
  import mempool_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_i,
  input  host_req_t           req_i,
  input  host_rsp_t           rsp_i,
  input  logic [NumCores-1:0] wake_up_i,
  input  data_t               eoc_i,
  input  logic                eoc_valid_i,
  input  logic                ro_cache_en_i,
  input  logic                busy_i,
  output int                  errors_o
);

  typedef struct packed {
    host_rsp_t           rsp;
    logic [NumCores-1:0] wake_up;
    data_t               eoc;
    logic                eoc_valid;
    logic                ro_cache_en;
  } expect_t;

  data_t     l2_model [NumL2Banks*L2BankNumWords];
  data_t     eoc_m;
  logic      eoc_valid_m;
  logic      ro_cache_en_m;
  expect_t   pending [$];            // One entry per cycle, due two edges later
  logic [1:0] valid_hist;            // Request valid seen at the last two edges
  string     test_name = "none";
  int        test_checks, test_errors;
  int        total_checks, total_errors, num_tests;

  assign errors_o = total_errors;

  // Expected response and side-band state after this request
  function automatic expect_t predict(host_req_t r);
    expect_t     e;
    logic [9:0]  widx;
    logic [3:0]  idx;
    e    = '0;
    widx = r.addr[11:2];
    idx  = r.addr[5:2];
    e.rsp.valid = r.valid;
    if (r.valid) begin
      if (r.addr >= L2MemoryBaseAddr && r.addr < L2MemoryBaseAddr + L2Size) begin
        if (r.we) begin
          for (int i = 0; i < 4; i++) begin
            if (r.strb[i]) begin
              l2_model[widx][i*8 +: 8] = r.wdata[i*8 +: 8];
            end
          end
        end else begin
          e.rsp.rdata = l2_model[widx];
        end
      end else if (r.addr >= BootromBaseAddr && r.addr <= BootromEndAddr) begin
        if (r.we) begin
          e.rsp.err = 1'b1;            // ROM write is illegal
        end else begin
          e.rsp.rdata = BootromContent[r.addr[4:2]];
        end
      end else if (r.addr[31:16] == 16'h4000 && r.addr[15:6] == '0 && idx <= 4'd5) begin
        case (idx)
          4'd0: begin
            if (r.we) begin
              eoc_m       = r.wdata;
              eoc_valid_m = 1'b1;
            end else begin
              e.rsp.rdata = eoc_m;
            end
          end
          4'd1: begin
            if (r.we) begin
              e.wake_up = r.wdata[3:0];
            end
          end
          4'd2: e.rsp.rdata = '0;     // TCDM starts at address zero
          4'd3: e.rsp.rdata = r.we ? '0 : 32'h0001_0000;
          4'd4: e.rsp.rdata = r.we ? '0 : 32'd4;
          default: begin
            if (r.we) begin
              ro_cache_en_m = r.wdata[0];
            end else begin
              e.rsp.rdata = {31'd0, ro_cache_en_m};
            end
          end
        endcase
      end else begin
        e.rsp.err = 1'b1;              // Unmapped or undefined register
      end
    end
    e.eoc         = eoc_m;
    e.eoc_valid   = eoc_valid_m;
    e.ro_cache_en = ro_cache_en_m;
    return e;
  endfunction

  task automatic compare_field(string field, logic [33:0] exp_v, logic [33:0] act_v);
    test_checks++;
    total_checks++;
    if (act_v !== exp_v) begin
      test_errors++;
      total_errors++;
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic start_test(string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    num_tests++;
    $display("Test %-8s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  task automatic report();
    $display("Tests run: %0d, checks: %0d, errors: %0d", num_tests, total_checks, total_errors);
  endtask

  always @(posedge clk_i) begin : compare
    expect_t due;
    if (rst_i) begin
      eoc_m         = '0;
      eoc_valid_m   = 1'b0;
      ro_cache_en_m = 1'b0;
      valid_hist    = '0;
      pending.delete();
      repeat (2) pending.push_back(predict('0)); // Outputs idle right after reset
    end else begin
      if (pending.size() == 2) begin
        due = pending.pop_front();
        compare_field("rsp", due.rsp, rsp_i);
        compare_field("wake_up", due.wake_up, wake_up_i);
        compare_field("eoc", due.eoc, eoc_i);
        compare_field("eoc_valid", due.eoc_valid, eoc_valid_i);
        compare_field("ro_cache_en", due.ro_cache_en, ro_cache_en_i);
      end
      compare_field("busy", |valid_hist, busy_i);
      valid_hist = {valid_hist[0], req_i.valid};
      pending.push_back(predict(req_i));
    end
  end

endmodule

//--- tb_mempool_system.sv
// ##########################################################################
// Drives single-word host requests, one per cycle at most, from an LFSR.
// The whole L2 is filled first so later reads never see unwritten words.
// ##########################################################################
`timescale 1ns/1ps

module tb_mempool_system
  import mempool_pkg::*;
();

  localparam int ClkPeriod   = 100;
  localparam int ResetCycles = 3;
  localparam int DrainCycles = 3;
  localparam int FillWords   = NumL2Banks * L2BankNumWords;
  localparam int L2Pairs     = 100;
  localparam int L2Reads     = 50;
  localparam int RomReads    = 32;
  localparam int CtrlOps     = 20;
  localparam int IllegalOps  = 24;
  localparam int ResetReads  = 32;
  localparam int TotalCycles = 2 * ResetCycles + FillWords + 2 * L2Pairs + L2Reads
                             + RomReads + 1 + CtrlOps + 2 * IllegalOps + ResetReads + 2
                             + 6 * DrainCycles;
  localparam int Margin      = 200;

  logic                clk = 1'b0;
  logic                rst;
  host_req_t           req;
  host_rsp_t           rsp;
  logic [NumCores-1:0] wake_up;
  data_t               eoc;
  logic                eoc_valid, ro_cache_en, busy;
  int                  errors;
  logic [31:0]         lfsr = 32'hc37e7ed4;

  always #(ClkPeriod / 2) clk = ~clk;

  mempool_system uut (
    .clk_i        (clk        ),
    .rst_i        (rst        ),
    .req_i        (req        ),
    .rsp_o        (rsp        ),
    .wake_up_o    (wake_up    ),
    .eoc_o        (eoc        ),
    .eoc_valid_o  (eoc_valid  ),
    .ro_cache_en_o(ro_cache_en),
    .busy_o       (busy       )
  );

  tb_mempool_checker chk (
    .clk_i        (clk        ),
    .rst_i        (rst        ),
    .req_i        (req        ),
    .rsp_i        (rsp        ),
    .wake_up_i    (wake_up    ),
    .eoc_i        (eoc        ),
    .eoc_valid_i  (eoc_valid  ),
    .ro_cache_en_i(ro_cache_en),
    .busy_i       (busy       ),
    .errors_o     (errors     )
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[31]};
    end
    return r;
  endfunction

  function automatic data_t fill_pattern(addr_t a);
    return a * 32'h9e37_79b1 + 32'h7f4a_7c15;
  endfunction

  function automatic addr_t reg_addr(int idx);
    return CtrlRegistersBaseAddr + 4 * idx;
  endfunction

  task automatic drive(logic we, addr_t addr, data_t wdata, strb_t strb);
    @(posedge clk);
    #1;
    req = '{valid: 1'b1, we: we, addr: addr, wdata: wdata, strb: strb};
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      req = '0;
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic finish_test();
    idle(DrainCycles);                 // Last response checked before the report
    chk.end_test();
  endtask

  // Watchdog
  initial begin
    #(ClkPeriod * (TotalCycles + Margin));
    $display("Timeout: tests still running after %0d cycles", TotalCycles + Margin);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    addr_t a;
    data_t d;
    rst = 1'b1;
    req = '0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;

    chk.start_test("fill");
    for (int i = 0; i < FillWords; i++) begin
      a = L2MemoryBaseAddr + 4 * i;
      drive(1'b1, a, fill_pattern(a), 4'hf);
    end
    finish_test();

    chk.start_test("l2_rw");
    for (int i = 0; i < L2Pairs; i++) begin
      a = L2MemoryBaseAddr + (take_bits(10) << 2);
      d = take_bits(32);
      drive(1'b1, a, d, strb_t'(take_bits(4)));
      drive(1'b0, a, '0, '0);          // Read right behind the write
    end
    for (int i = 0; i < L2Reads; i++) begin
      drive(1'b0, L2MemoryBaseAddr + (take_bits(10) << 2), '0, '0);
    end
    finish_test();

    chk.start_test("bootrom");
    for (int i = 0; i < RomReads; i++) begin
      drive(1'b0, BootromBaseAddr + (take_bits(14) << 2), '0, '0);
    end
    drive(1'b1, BootromBaseAddr + 4, take_bits(32), 4'hf);
    finish_test();

    chk.start_test("ctrl");
    drive(1'b0, reg_addr(2), '0, '0);
    drive(1'b0, reg_addr(3), '0, '0);
    drive(1'b0, reg_addr(4), '0, '0);
    drive(1'b1, reg_addr(5), 32'h1, 4'hf);
    drive(1'b0, reg_addr(5), '0, '0);
    drive(1'b1, reg_addr(0), take_bits(32), 4'hf);
    drive(1'b0, reg_addr(0), '0, '0);
    drive(1'b1, reg_addr(1), take_bits(32), 4'hf);
    idle(2);                           // Lone wake-up pulse
    drive(1'b1, reg_addr(1), take_bits(32), 4'hf);
    drive(1'b1, reg_addr(1), take_bits(32), 4'hf);
    drive(1'b0, reg_addr(1), '0, '0);
    drive(1'b1, reg_addr(5), 32'h0, 4'hf);
    drive(1'b0, reg_addr(5), '0, '0);
    drive(1'b1, reg_addr(5), 32'h3, 4'hf);
    finish_test();

    chk.start_test("illegal");
    for (int i = 0; i < IllegalOps; i++) begin
      d = take_bits(30);
      case (take_bits(2))
        0: a = {2'b00, d[29:0]};
        1: a = L2MemoryBaseAddr + L2Size + d[11:0];
        2: a = reg_addr(6 + d[2:0]);   // No register behind these indices
        default: a = {2'b11, d[29:0]};
      endcase
      drive(i[0], a, take_bits(32), 4'hf);
      drive(1'b0, L2MemoryBaseAddr + {a[11:2], 2'b00}, '0, '0);
    end
    finish_test();

    chk.start_test("reset");
    apply_reset();
    for (int i = 0; i < ResetReads; i++) begin
      drive(1'b0, L2MemoryBaseAddr + (take_bits(10) << 2), '0, '0);
    end
    drive(1'b0, reg_addr(0), '0, '0);
    drive(1'b0, reg_addr(5), '0, '0);
    finish_test();

    chk.report();
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- all.f
mempool_pkg.sv
mempool_addr_decode.sv
mempool_l2_banks.sv
mempool_bootrom.sv
mempool_ctrl_registers.sv
mempool_resp_merge.sv
mempool_system.sv
tb_mempool_checker.sv
tb_mempool_system.sv
